/* src/imu_link_pkg.sv */
package imu_link_pkg;

    // ==================================================
    // Packet geometry
    // ==================================================

    // One attitude packet is 16 bytes, shifted in MSB first
    localparam int packet_bytes = 16;
    localparam int packet_bits  = packet_bytes * 8;

    // Bit counter for one packet, wraps to zero after the last bit
    typedef logic [$clog2(packet_bits) - 1:0] bit_count_t;

    // Raw packet with byte 0 in the top eight bits
    typedef logic [packet_bits - 1:0] frame_t;

    // Signed sensor word, MSB byte first on the wire
    typedef logic signed [15:0] sample_t;

    // ==================================================
    // Packet layout
    // ==================================================

    // Byte 0 must carry this value or the packet is rejected
    localparam logic [7:0] header_value = 8'hAA;

    // Byte index of the first (most significant) byte of each field
    localparam int roll_offset   = 1;
    localparam int pitch_offset  = 3;
    localparam int yaw_offset    = 5;
    localparam int gyro_x_offset = 7;
    localparam int gyro_y_offset = 9;
    localparam int gyro_z_offset = 11;
    localparam int flags_offset  = 13;

    // Validity bits inside the flags byte, bytes 14 and 15 are reserved
    localparam int euler_valid_bit = 0;
    localparam int gyro_valid_bit  = 1;

    // Synchronized cs_n high cycles before the frame buffer is read
    localparam int settle_cycles = 3;
    typedef logic [$clog2(settle_cycles + 1) - 1:0] settle_count_t;

endpackage

/* src/spi_frame_receiver.sv */
`timescale 1ns/1ps

module spi_frame_receiver (
    input  logic                 sck,
    input  logic                 arst_n,
    input  logic                 cs_n,
    input  logic                 sdi,
    output imu_link_pkg::frame_t frame,
    output logic                 frame_toggle
);

    // ==================================================
    // SPI Mode 0 receive path, sck domain
    // ==================================================

    imu_link_pkg::frame_t     shift_reg;
    imu_link_pkg::frame_t     shift_next;
    imu_link_pkg::bit_count_t bit_count;
    logic                     count_rst_n;
    logic                     last_bit;

    // New bit enters at the bottom, so the first bit ends up in the MSB
    assign shift_next = {shift_reg[imu_link_pkg::packet_bits - 2:0], sdi};

    // Counter value while the 128th bit of a packet is on sdi
    assign last_bit = (bit_count == imu_link_pkg::bit_count_t'(imu_link_pkg::packet_bits - 1));

    // The counter is held at zero for as long as the master is deselected
    // sck is idle then, so the clear cannot wait for an sck edge
    // This also discards the count of a truncated transaction
    assign count_rst_n = arst_n & ~cs_n;

    // Data shifter, only moves while the slave is selected
    always_ff @(posedge sck) begin
        if (!cs_n) begin
            shift_reg <= shift_next;
        end
    end

    // Bit counter wraps naturally from 127 to 0 at the end of each packet
    // so back to back packets in one select period line up on byte 0
    always_ff @(posedge sck or negedge count_rst_n) begin
        if (!count_rst_n) begin
            bit_count <= '0;
        end else begin
            bit_count <= bit_count + 1'b1;
        end
    end

    // ==================================================
    // Completed frame buffer
    // ==================================================

    // On the last bit the buffer takes the shifter including the new bit
    // The toggle flips on the same edge and tells the clk side a full
    // frame is waiting; a later packet simply overwrites the buffer
    always_ff @(posedge sck or negedge arst_n) begin
        if (!arst_n) begin
            frame        <= '0;
            frame_toggle <= 1'b0;
        end else if (!cs_n && last_bit) begin
            frame        <= shift_next;
            frame_toggle <= ~frame_toggle;
        end
    end

    // Note the buffer is left alone after a short transaction, which
    // means the toggle does not move and the clk side sees nothing new

endmodule

/* src/frame_sync.sv */
`timescale 1ns/1ps

module frame_sync (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 cs_n,
    input  imu_link_pkg::frame_t frame,
    input  logic                 frame_toggle,
    output imu_link_pkg::frame_t snap_frame,
    output logic                 frame_strobe
);

    // ==================================================
    // Two stage synchronizers
    // ==================================================

    logic cs_meta;
    logic cs_sync;
    logic toggle_meta;
    logic toggle_sync;

    // cs_n resets to the deselected level so nothing happens out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cs_meta     <= 1'b1;
            cs_sync     <= 1'b1;
            toggle_meta <= 1'b0;
            toggle_sync <= 1'b0;
        end else begin
            cs_meta     <= cs_n;
            cs_sync     <= cs_meta;
            toggle_meta <= frame_toggle;
            toggle_sync <= toggle_meta;
        end
    end

    // ==================================================
    // Chip select settle counter
    // ==================================================

    imu_link_pkg::settle_count_t settle_count;
    logic                        settled;

    assign settled = (settle_count == imu_link_pkg::settle_count_t'(imu_link_pkg::settle_cycles));

    // Counts synchronized high cycles of cs_n and saturates at the limit
    // Any low cycle restarts the count from zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            settle_count <= '0;
        end else if (!cs_sync) begin
            settle_count <= '0;
        end else if (!settled) begin
            settle_count <= settle_count + 1'b1;
        end
    end

    // ==================================================
    // Snapshot control
    // ==================================================

    logic toggle_prev;
    logic frame_pending;
    logic read_done;
    logic read_now;

    // Read once per high period and only if a frame completed since the last read
    // The frame buffer is quiet because sck idles while cs_n is high
    // The toggle alone does not make the bus safe to sample
    assign read_now = settled && frame_pending && !read_done;

    // Every edge of the synchronized toggle marks one completed frame
    // An even number of frames in one select period leaves the toggle at its
    // old level, so each edge sets a pending flag that the read clears
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            toggle_prev   <= 1'b0;
            frame_pending <= 1'b0;
            read_done     <= 1'b0;
            frame_strobe  <= 1'b0;
        end else begin
            toggle_prev  <= toggle_sync;
            frame_strobe <= read_now;
            if (toggle_sync != toggle_prev) begin
                frame_pending <= 1'b1;
            end else if (read_now) begin
                frame_pending <= 1'b0;
            end
            if (read_now) begin
                read_done <= 1'b1;
            end else if (!cs_sync) begin
                // A new transaction has started and arms the next high period
                read_done <= 1'b0;
            end
        end
    end

    // All 128 bits are copied in one clk edge so the decoder never sees
    // a mix of two packets
    // The strobe rises on the same edge as the copy and lasts one cycle
    always_ff @(posedge clk) begin
        if (read_now) begin
            snap_frame <= frame;
        end
    end

    // A 64 bit transaction completes no frame, so read_now stays low
    // and snap_frame keeps the previous packet

endmodule

/* src/packet_decoder.sv */
`timescale 1ns/1ps

module packet_decoder (
    input  logic                  clk,
    input  logic                  arst_n,
    input  imu_link_pkg::frame_t  snap_frame,
    input  logic                  frame_strobe,
    output logic                  update,
    output logic                  initialized,
    output logic                  error,
    output logic                  euler_valid,
    output logic                  gyro_valid,
    output imu_link_pkg::sample_t roll,
    output imu_link_pkg::sample_t pitch,
    output imu_link_pkg::sample_t yaw,
    output imu_link_pkg::sample_t gyro_x,
    output imu_link_pkg::sample_t gyro_y,
    output imu_link_pkg::sample_t gyro_z
);

    // ==================================================
    // Field extraction
    // ==================================================

    localparam int top_bit = imu_link_pkg::packet_bits - 1;

    logic [7:0]            header;
    logic [7:0]            flags;
    logic                  header_ok;
    imu_link_pkg::sample_t roll_field;
    imu_link_pkg::sample_t pitch_field;
    imu_link_pkg::sample_t yaw_field;
    imu_link_pkg::sample_t gyro_x_field;
    imu_link_pkg::sample_t gyro_y_field;
    imu_link_pkg::sample_t gyro_z_field;

    // Byte n of the packet starts at bit 127 - 8n
    // Each sample takes two bytes, MSB byte first
    assign header       = snap_frame[top_bit -: 8];
    assign flags        = snap_frame[top_bit - 8 * imu_link_pkg::flags_offset -: 8];
    assign roll_field   = snap_frame[top_bit - 8 * imu_link_pkg::roll_offset -: 16];
    assign pitch_field  = snap_frame[top_bit - 8 * imu_link_pkg::pitch_offset -: 16];
    assign yaw_field    = snap_frame[top_bit - 8 * imu_link_pkg::yaw_offset -: 16];
    assign gyro_x_field = snap_frame[top_bit - 8 * imu_link_pkg::gyro_x_offset -: 16];
    assign gyro_y_field = snap_frame[top_bit - 8 * imu_link_pkg::gyro_y_offset -: 16];
    assign gyro_z_field = snap_frame[top_bit - 8 * imu_link_pkg::gyro_z_offset -: 16];

    // Bytes 14 and 15 are reserved and not decoded

    assign header_ok = (header == imu_link_pkg::header_value);

    // ==================================================
    // Link status
    // ==================================================

    // Status follows the header of the latest packet and holds in between
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            update      <= 1'b0;
            initialized <= 1'b0;
            error       <= 1'b0;
        end else begin
            update <= frame_strobe;
            if (frame_strobe) begin
                initialized <= header_ok;
                error       <= !header_ok;
            end
        end
    end

    // ==================================================
    // Sample and valid flag registers
    // ==================================================

    // Loaded only from a packet with a good header, so a corrupt packet
    // leaves the last good attitude in place
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            euler_valid <= 1'b0;
            gyro_valid  <= 1'b0;
            roll        <= '0;
            pitch       <= '0;
            yaw         <= '0;
            gyro_x      <= '0;
            gyro_y      <= '0;
            gyro_z      <= '0;
        end else if (frame_strobe && header_ok) begin
            euler_valid <= flags[imu_link_pkg::euler_valid_bit];
            gyro_valid  <= flags[imu_link_pkg::gyro_valid_bit];
            roll        <= roll_field;
            pitch       <= pitch_field;
            yaw         <= yaw_field;
            gyro_x      <= gyro_x_field;
            gyro_y      <= gyro_y_field;
            gyro_z      <= gyro_z_field;
        end
    end

endmodule

/* src/imu_spi_link_top.sv */
`timescale 1ns/1ps

module imu_spi_link_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  cs_n,
    input  logic                  sck,
    input  logic                  sdi,
    output logic                  update,
    output logic                  initialized,
    output logic                  error,
    output logic                  euler_valid,
    output logic                  gyro_valid,
    output imu_link_pkg::sample_t roll,
    output imu_link_pkg::sample_t pitch,
    output imu_link_pkg::sample_t yaw,
    output imu_link_pkg::sample_t gyro_x,
    output imu_link_pkg::sample_t gyro_y,
    output imu_link_pkg::sample_t gyro_z
);

    // Completed frame and its toggle live in the sck domain
    imu_link_pkg::frame_t frame;
    logic                 frame_toggle;

    // Snapshot and its strobe live in the clk domain
    imu_link_pkg::frame_t snap_frame;
    logic                 frame_strobe;

    // ==================================================
    // Receive, cross, decode
    // ==================================================

    spi_frame_receiver u_receiver (
        .sck          (sck),
        .arst_n       (arst_n),
        .cs_n         (cs_n),
        .sdi          (sdi),
        .frame        (frame),
        .frame_toggle (frame_toggle)
    );

    // cs_n goes to both stages; the sync stage waits for it to settle high
    frame_sync u_sync (
        .clk          (clk),
        .arst_n       (arst_n),
        .cs_n         (cs_n),
        .frame        (frame),
        .frame_toggle (frame_toggle),
        .snap_frame   (snap_frame),
        .frame_strobe (frame_strobe)
    );

    packet_decoder u_decoder (
        .clk          (clk),
        .arst_n       (arst_n),
        .snap_frame   (snap_frame),
        .frame_strobe (frame_strobe),
        .update       (update),
        .initialized  (initialized),
        .error        (error),
        .euler_valid  (euler_valid),
        .gyro_valid   (gyro_valid),
        .roll         (roll),
        .pitch        (pitch),
        .yaw          (yaw),
        .gyro_x       (gyro_x),
        .gyro_y       (gyro_y),
        .gyro_z       (gyro_z)
    );

endmodule

/* dv/imu_spi_link_tb.sv */
`timescale 1ns/1ps

module imu_spi_link_tb;

    localparam int num_tests      = 8;
    localparam int timeout_cycles = 20;
    localparam int gap_cycles     = 30;
    localparam int half_period    = 3;
    localparam int top_bit        = imu_link_pkg::packet_bits - 1;

    logic                  clk;
    logic                  arst_n;
    logic                  cs_n;
    logic                  sck;
    logic                  sdi;
    logic                  update;
    logic                  initialized;
    logic                  error;
    logic                  euler_valid;
    logic                  gyro_valid;
    imu_link_pkg::sample_t roll;
    imu_link_pkg::sample_t pitch;
    imu_link_pkg::sample_t yaw;
    imu_link_pkg::sample_t gyro_x;
    imu_link_pkg::sample_t gyro_y;
    imu_link_pkg::sample_t gyro_z;

    // ==================================================
    // Stimulus table and expected values
    // ==================================================

    string                 tbl_name    [num_tests];
    int                    tbl_packets [num_tests];
    int                    tbl_bits    [num_tests];
    logic [7:0]            tbl_header  [num_tests];
    logic [7:0]            tbl_flags   [num_tests];
    imu_link_pkg::sample_t tbl_sample  [num_tests][6];
    bit                    exp_update  [num_tests];
    logic                  exp_init    [num_tests];
    logic                  exp_error   [num_tests];
    logic                  exp_euler   [num_tests];
    logic                  exp_gyro    [num_tests];
    imu_link_pkg::sample_t exp_sample  [num_tests][6];

    int error_count = 0;
    int pass_count  = 0;
    int fail_count  = 0;

    imu_spi_link_top u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .cs_n        (cs_n),
        .sck         (sck),
        .sdi         (sdi),
        .update      (update),
        .initialized (initialized),
        .error       (error),
        .euler_valid (euler_valid),
        .gyro_valid  (gyro_valid),
        .roll        (roll),
        .pitch       (pitch),
        .yaw         (yaw),
        .gyro_x      (gyro_x),
        .gyro_y      (gyro_y),
        .gyro_z      (gyro_z)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic set_entry(input int idx, input string name, input int packets,
                             input int bits, input logic [7:0] header, input logic [7:0] flags);
        tbl_name[idx]    = name;
        tbl_packets[idx] = packets;
        tbl_bits[idx]    = bits;
        tbl_header[idx]  = header;
        tbl_flags[idx]   = flags;
    endtask

    // Later entries expect the state left by earlier ones
    task automatic load_table();
        set_entry(0, "reset_state", 0, imu_link_pkg::packet_bits, 8'hAA, 8'h00);
        set_entry(1, "good_flags_3", 1, imu_link_pkg::packet_bits, 8'hAA, 8'h03);
        set_entry(2, "good_flags_1", 1, imu_link_pkg::packet_bits, 8'hAA, 8'h01);
        set_entry(3, "good_flags_2", 1, imu_link_pkg::packet_bits, 8'hAA, 8'h02);
        set_entry(4, "bad_header", 1, imu_link_pkg::packet_bits, 8'h55, 8'h03);
        set_entry(5, "truncated_64", 1, 64, 8'hAA, 8'h03);
        set_entry(6, "good_after_truncated", 1, imu_link_pkg::packet_bits, 8'hAA, 8'h03);
        set_entry(7, "two_packets", 2, imu_link_pkg::packet_bits, 8'hAA, 8'h01);
        for (int i = 0; i < num_tests; i++) begin
            for (int k = 0; k < 6; k++) begin
                tbl_sample[i][k] = imu_link_pkg::sample_t'($urandom());
            end
        end
    endtask

    // Reference model of the link status and data registers
    // A select period that completes at least one full frame gives one update
    task automatic derive_expected();
        logic                  m_init;
        logic                  m_error;
        logic                  m_euler;
        logic                  m_gyro;
        imu_link_pkg::sample_t m_sample [6];
        m_init  = 1'b0;
        m_error = 1'b0;
        m_euler = 1'b0;
        m_gyro  = 1'b0;
        for (int k = 0; k < 6; k++) begin
            m_sample[k] = '0;
        end
        for (int i = 0; i < num_tests; i++) begin
            exp_update[i] = (tbl_packets[i] > 0) &&
                            (tbl_bits[i] == imu_link_pkg::packet_bits);
            if (exp_update[i]) begin
                // The last packet of the select period is the one that counts
                if (tbl_header[i] == imu_link_pkg::header_value) begin
                    m_init  = 1'b1;
                    m_error = 1'b0;
                    m_euler = tbl_flags[i][imu_link_pkg::euler_valid_bit];
                    m_gyro  = tbl_flags[i][imu_link_pkg::gyro_valid_bit];
                    for (int k = 0; k < 6; k++) begin
                        m_sample[k] = tbl_sample[i][k];
                    end
                end else begin
                    m_init  = 1'b0;
                    m_error = 1'b1;
                end
            end
            exp_init[i]  = m_init;
            exp_error[i] = m_error;
            exp_euler[i] = m_euler;
            exp_gyro[i]  = m_gyro;
            for (int k = 0; k < 6; k++) begin
                exp_sample[i][k] = m_sample[k];
            end
        end
    endtask

    // Leading packets of a multi packet send carry inverted samples and flags 2
    function automatic imu_link_pkg::frame_t build_frame(input int idx, input bit lead);
        imu_link_pkg::frame_t f;
        int                   offs [6];
        offs = '{imu_link_pkg::roll_offset, imu_link_pkg::pitch_offset,
                 imu_link_pkg::yaw_offset, imu_link_pkg::gyro_x_offset,
                 imu_link_pkg::gyro_y_offset, imu_link_pkg::gyro_z_offset};
        f = '0;
        f[top_bit -: 8] = lead ? imu_link_pkg::header_value : tbl_header[idx];
        for (int k = 0; k < 6; k++) begin
            f[top_bit - 8 * offs[k] -: 16] = lead ? ~tbl_sample[idx][k] : tbl_sample[idx][k];
        end
        f[top_bit - 8 * imu_link_pkg::flags_offset -: 8] = lead ? 8'h02 : tbl_flags[idx];
        // Reserved bytes get a pattern the decoder must ignore
        f[15:0] = 16'h5AC3;
        return f;
    endfunction

    // ==================================================
    // SPI master driver, Mode 0, MSB first
    // ==================================================

    task automatic send_transaction(input int idx);
        imu_link_pkg::frame_t pkt;
        @(posedge clk);
        cs_n <= 1'b0;
        sck  <= 1'b0;
        repeat (half_period) @(posedge clk);
        for (int p = 0; p < tbl_packets[idx]; p++) begin
            pkt = build_frame(idx, p != tbl_packets[idx] - 1);
            for (int i = 0; i < tbl_bits[idx]; i++) begin
                // Data changes while sck is low and the slave samples it on the rise
                sdi <= pkt[top_bit - i];
                repeat (half_period) @(posedge clk);
                sck <= 1'b1;
                repeat (half_period) @(posedge clk);
                sck <= 1'b0;
            end
        end
        repeat (half_period) @(posedge clk);
        cs_n <= 1'b1;
        sdi  <= 1'b0;
    endtask

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic run_test(input int idx);
        int errors_before;
        int cycles;
        bit seen;
        errors_before = error_count;
        cycles        = 0;
        seen          = 1'b0;
        repeat (gap_cycles) @(posedge clk);
        if (tbl_packets[idx] > 0) begin
            send_transaction(idx);
        end
        // Outputs are read on the falling edge half a cycle after they load
        while (!seen && cycles < timeout_cycles) begin
            @(negedge clk);
            seen = update;
            cycles++;
        end
        if (exp_update[idx] && !seen) begin
            $display("Test %0d timed out after %0d cycles waiting for update", idx, cycles);
            error_count++;
        end else if (!exp_update[idx] && seen) begin
            $display("Test %0d saw an update pulse where none should occur", idx);
            error_count++;
        end
        check_value("initialized", 16'(initialized), 16'(exp_init[idx]));
        check_value("error", 16'(error), 16'(exp_error[idx]));
        check_value("euler_valid", 16'(euler_valid), 16'(exp_euler[idx]));
        check_value("gyro_valid", 16'(gyro_valid), 16'(exp_gyro[idx]));
        check_value("roll", roll, exp_sample[idx][0]);
        check_value("pitch", pitch, exp_sample[idx][1]);
        check_value("yaw", yaw, exp_sample[idx][2]);
        check_value("gyro_x", gyro_x, exp_sample[idx][3]);
        check_value("gyro_y", gyro_y, exp_sample[idx][4]);
        check_value("gyro_z", gyro_z, exp_sample[idx][5]);
        if (error_count == errors_before) begin
            pass_count++;
            $display("Test %0d %s: pass", idx, tbl_name[idx]);
        end else begin
            fail_count++;
            $display("Test %0d %s: fail", idx, tbl_name[idx]);
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        int unsigned seed_ret;
        arst_n <= 1'b0;
        cs_n   <= 1'b1;
        sck    <= 1'b0;
        sdi    <= 1'b0;
        seed_ret = $urandom(32'hf78bd868);
        load_table();
        derive_expected();
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < num_tests; i++) begin
            run_test(i);
        end
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 num_tests, pass_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
src/imu_link_pkg.sv
src/spi_frame_receiver.sv
src/frame_sync.sv
src/packet_decoder.sv
src/imu_spi_link_top.sv
dv/imu_spi_link_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the IMU SPI link testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir
TOP=imu_spi_link_tb

rm -f "$LOG"

verilator --binary -j 0 \
    --timescale 1ns/1ps \
    --top-module "$TOP" \
    --Mdir "$OBJ_DIR" \
    -f filelist.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

# The verdict comes from the log alone
if grep -q "^Simulation PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
